//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes in bits 6:0 of every instruction
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Integer operations, shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_alt = 7'b0100000; // Turns ADD into SUB and SRL into SRA

    // One struct per format, each exactly 32 bits wide with the opcode at the bottom
    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } rv_fmt_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0]  rd;       logic [6:0] opcode;
    } rv_fmt_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3;   logic [4:0] imm_4_0; logic [6:0] opcode;
    } rv_fmt_s_t;

    typedef struct packed {
        logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } rv_fmt_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
    } rv_fmt_u_t;

    typedef struct packed {
        logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
        logic [4:0] rd; logic [6:0] opcode;
    } rv_fmt_j_t;

    // Same word seen through each format
    typedef union packed {
        rv_fmt_r_t r;
        rv_fmt_i_t i;
        rv_fmt_s_t s;
        rv_fmt_b_t b;
        rv_fmt_u_t u;
        rv_fmt_j_t j;
    } rv_instr_u;

endpackage

//--- src/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    localparam int alu_ctrl_w = 4;

    // ALU operation codes. Add is zero so a reset stage computes 0 + 0
    localparam logic [alu_ctrl_w-1:0] alu_add    = 4'd0;
    localparam logic [alu_ctrl_w-1:0] alu_sub    = 4'd1;
    localparam logic [alu_ctrl_w-1:0] alu_sll    = 4'd2;
    localparam logic [alu_ctrl_w-1:0] alu_slt    = 4'd3;
    localparam logic [alu_ctrl_w-1:0] alu_sltu   = 4'd4;
    localparam logic [alu_ctrl_w-1:0] alu_xor    = 4'd5;
    localparam logic [alu_ctrl_w-1:0] alu_srl    = 4'd6;
    localparam logic [alu_ctrl_w-1:0] alu_sra    = 4'd7;
    localparam logic [alu_ctrl_w-1:0] alu_or     = 4'd8;
    localparam logic [alu_ctrl_w-1:0] alu_and    = 4'd9;
    localparam logic [alu_ctrl_w-1:0] alu_pass_b = 4'd10; // LUI puts the immediate straight through

    // First ALU operand source
    localparam int op_a_sel_w = 2;
    localparam logic [op_a_sel_w-1:0] a_rs1  = 2'd0;
    localparam logic [op_a_sel_w-1:0] a_pc   = 2'd1;
    localparam logic [op_a_sel_w-1:0] a_zero = 2'd2;

    // Second ALU operand source
    localparam logic b_rs2 = 1'b0;
    localparam logic b_imm = 1'b1;

    // What kind of control transfer the instruction may cause
    localparam int jump_kind_w = 2;
    localparam logic [jump_kind_w-1:0] jmp_none   = 2'd0;
    localparam logic [jump_kind_w-1:0] jmp_branch = 2'd1; // Taken only when the funct3 compare holds
    localparam logic [jump_kind_w-1:0] jmp_jal    = 2'd2;
    localparam logic [jump_kind_w-1:0] jmp_jalr   = 2'd3;

endpackage

//--- src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_isa_pkg::rv_instr_u                instr,
    output logic [rv_ctrl_pkg::alu_ctrl_w-1:0]   alu_ctrl,
    output logic [rv_ctrl_pkg::op_a_sel_w-1:0]   op_a_sel,
    output logic                                 op_b_sel,
    output logic [rv_ctrl_pkg::jump_kind_w-1:0]  jump_kind,
    output logic [2:0]                           funct3,
    output logic [31:0]                          imm,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic                                 reg_write,
    output logic                                 mem_to_reg,
    output logic [4:0]                           rd
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic writes_rd; // Instruction format carries a destination register

    // Shared funct3 decode for OP and OP-IMM; alt is the funct7 bit that flips SUB and SRA
    function automatic logic [alu_ctrl_w-1:0] alu_decode(input logic [2:0] f3,
                                                         input logic allow_sub,
                                                         input logic alt);
        case (f3)
            f3_add_sub: alu_decode = (allow_sub && alt) ? alu_sub : alu_add;
            f3_sll:     alu_decode = alu_sll;
            f3_slt:     alu_decode = alu_slt;
            f3_sltu:    alu_decode = alu_sltu;
            f3_xor:     alu_decode = alu_xor;
            f3_srl_sra: alu_decode = alt ? alu_sra : alu_srl; // Shift-immediates also use funct7
            f3_or:      alu_decode = alu_or;
            default:    alu_decode = alu_and;
        endcase
    endfunction

    always_comb
    begin
        // Defaults describe a bubble
        alu_ctrl   = alu_add;
        op_a_sel   = a_rs1;
        op_b_sel   = b_rs2;
        jump_kind  = jmp_none;
        funct3     = instr.r.funct3;
        imm        = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        writes_rd  = 1'b0;

        case (instr.r.opcode)
            opc_lui:
            begin
                alu_ctrl  = alu_pass_b;
                op_a_sel  = a_zero;
                op_b_sel  = b_imm;
                imm       = {instr.u.imm_31_12, 12'b0};
                writes_rd = 1'b1;
            end
            opc_auipc:
            begin
                op_a_sel  = a_pc;  // pc + upper immediate
                op_b_sel  = b_imm;
                imm       = {instr.u.imm_31_12, 12'b0};
                writes_rd = 1'b1;
            end
            opc_jal:
            begin
                jump_kind = jmp_jal;
                op_a_sel  = a_pc;
                op_b_sel  = b_imm;
                imm       = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                             instr.j.imm_10_1, 1'b0};
                writes_rd = 1'b1; // Link register gets pc + 4
            end
            opc_jalr:
            begin
                jump_kind = jmp_jalr;
                op_b_sel  = b_imm;
                imm       = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
                writes_rd = 1'b1;
            end
            opc_branch:
            begin
                jump_kind = jmp_branch;
                alu_ctrl  = alu_sub; // Compare itself happens in the execute stage
                imm       = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                             instr.b.imm_4_1, 1'b0};
            end
            opc_load:
            begin
                op_b_sel   = b_imm;
                imm        = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                writes_rd  = 1'b1;
            end
            opc_store:
            begin
                op_b_sel  = b_imm;
                imm       = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
                mem_write = 1'b1;
            end
            opc_op_imm:
            begin
                alu_ctrl  = alu_decode(instr.i.funct3, 1'b0, instr.r.funct7 == f7_alt);
                op_b_sel  = b_imm;
                imm       = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
                writes_rd = 1'b1;
            end
            opc_op:
            begin
                alu_ctrl  = alu_decode(instr.r.funct3, 1'b1, instr.r.funct7 == f7_alt);
                writes_rd = 1'b1;
            end
            default:
            begin
                writes_rd = 1'b0; // Unknown, CSR, fence and system all stay bubbles
            end
        endcase
    end

    // Formats without rd report x0, and x0 is never written
    assign rd        = writes_rd ? instr.r.rd : 5'd0;
    assign reg_write = writes_rd && (instr.r.rd != 5'd0);

endmodule

//--- src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_ctrl_pkg::alu_ctrl_w-1:0] alu_ctrl,
    input  logic [31:0]                        a,
    input  logic [31:0]                        b,
    output logic [31:0]                        result
);
    import rv_ctrl_pkg::*;

    logic [4:0] shamt; // Only the low five bits of b count for shifts

    assign shamt = b[4:0];

    always_comb
    begin
        case (alu_ctrl)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:
            begin
                // Signed compare, result is 0 or 1
                result = {31'b0, $signed(a) < $signed(b)};
            end
            alu_sltu:   result = {31'b0, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:
            begin
                // Arithmetic shift keeps the sign bit
                result = $unsigned($signed(a) >>> shamt);
            end
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0; // Unused codes give zero
        endcase
    end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [rv_ctrl_pkg::alu_ctrl_w-1:0]   alu_ctrl,
    input  logic [rv_ctrl_pkg::op_a_sel_w-1:0]   op_a_sel,
    input  logic                                 op_b_sel,
    input  logic [rv_ctrl_pkg::jump_kind_w-1:0]  jump_kind,
    input  logic [2:0]                           funct3,
    input  logic [31:0]                          imm,
    input  logic                                 mem_read_in,
    input  logic                                 mem_write_in,
    input  logic                                 reg_write_in,
    input  logic                                 mem_to_reg_in,
    input  logic [4:0]                           rd_in,
    input  logic [31:0]                          rs1_value,
    input  logic [31:0]                          rs2_value,
    input  logic [31:0]                          pc,
    input  logic [31:0]                          alu_result,
    output logic [rv_ctrl_pkg::alu_ctrl_w-1:0]   alu_ctrl_q,
    output logic [31:0]                          alu_a,
    output logic [31:0]                          alu_b,
    output logic [31:0]                          result,
    output logic [31:0]                          target,
    output logic                                 take_jump,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic                                 reg_write,
    output logic                                 mem_to_reg,
    output logic [4:0]                           rd,
    output logic [31:0]                          store_data
);
    import rv_ctrl_pkg::*;

    logic [op_a_sel_w-1:0]  op_a_sel_q;
    logic                   op_b_sel_q;
    logic [jump_kind_w-1:0] jump_kind_q;
    logic [2:0]             funct3_q;
    logic [31:0]            imm_q, rs1_q, pc_q;
    logic                   branch_cond;      // funct3 comparison of rs1 and rs2
    logic                   is_jump;          // JAL or JALR, always taken
    logic [31:0]            jalr_sum;

    // Stage register, every field cleared so a reset stage looks like a bubble
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            alu_ctrl_q  <= '0;
            op_a_sel_q  <= '0;
            op_b_sel_q  <= 1'b0;
            jump_kind_q <= '0;
            funct3_q    <= '0;
            imm_q       <= '0;
            rs1_q       <= '0;
            store_data  <= '0;
            pc_q        <= '0;
            mem_read    <= 1'b0;
            mem_write   <= 1'b0;
            reg_write   <= 1'b0;
            mem_to_reg  <= 1'b0;
            rd          <= '0;
        end
        else
        begin
            alu_ctrl_q  <= alu_ctrl;
            op_a_sel_q  <= op_a_sel;
            op_b_sel_q  <= op_b_sel;
            jump_kind_q <= jump_kind;
            funct3_q    <= funct3;
            imm_q       <= imm;
            rs1_q       <= rs1_value;
            store_data  <= rs2_value; // Registered rs2 also feeds the compare and operand b
            pc_q        <= pc;
            mem_read    <= mem_read_in;
            mem_write   <= mem_write_in;
            reg_write   <= reg_write_in;
            mem_to_reg  <= mem_to_reg_in;
            rd          <= rd_in;
        end
    end

    // Operand multiplexers in front of the ALU
    always_comb
    begin
        case (op_a_sel_q)
            a_rs1:   alu_a = rs1_q;
            a_pc:    alu_a = pc_q;
            default: alu_a = '0; // a_zero for LUI
        endcase
    end

    assign alu_b = (op_b_sel_q == b_imm) ? imm_q : store_data;

    // Branch condition, funct3 values 010 and 011 never take
    always_comb
    begin
        case (funct3_q)
            3'b000:  branch_cond = (rs1_q == store_data);
            3'b001:  branch_cond = (rs1_q != store_data);
            3'b100:  branch_cond = ($signed(rs1_q) <  $signed(store_data));
            3'b101:  branch_cond = ($signed(rs1_q) >= $signed(store_data));
            3'b110:  branch_cond = (rs1_q <  store_data);
            3'b111:  branch_cond = (rs1_q >= store_data);
            default: branch_cond = 1'b0;
        endcase
    end

    assign is_jump   = (jump_kind_q == jmp_jal) || (jump_kind_q == jmp_jalr);
    assign take_jump = is_jump || ((jump_kind_q == jmp_branch) && branch_cond);

    // Jumps write the link value; everything else writes the ALU output
    assign result = is_jump ? pc_q + 32'd4 : alu_result;

    assign jalr_sum = rs1_q + imm_q;
    assign target   = (jump_kind_q == jmp_jalr) ? {jalr_sum[31:1], 1'b0} : pc_q + imm_q;

endmodule

//--- src/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    input  logic [31:0] pc,
    output logic [31:0] result,
    output logic [31:0] target,
    output logic        take_jump,
    output logic        mem_read,
    output logic        mem_write,
    output logic [31:0] store_data,
    output logic        reg_write,
    output logic        mem_to_reg,
    output logic [4:0]  rd
);
    import rv_ctrl_pkg::*;

    // Decoder outputs, sampled by the execute stage
    logic [alu_ctrl_w-1:0]  alu_ctrl;
    logic [op_a_sel_w-1:0]  op_a_sel;
    logic                   op_b_sel;
    logic [jump_kind_w-1:0] jump_kind;
    logic [2:0]             funct3;
    logic [31:0]            imm;
    logic                   dec_mem_read, dec_mem_write, dec_reg_write, dec_mem_to_reg;
    logic [4:0]             dec_rd;

    // Loop between the execute stage and the ALU
    logic [alu_ctrl_w-1:0]  alu_ctrl_q;
    logic [31:0]            alu_a, alu_b, alu_result;

    rv_decoder dec0 (
        .instr(instr), .alu_ctrl(alu_ctrl), .op_a_sel(op_a_sel), .op_b_sel(op_b_sel),
        .jump_kind(jump_kind), .funct3(funct3), .imm(imm), .mem_read(dec_mem_read),
        .mem_write(dec_mem_write), .reg_write(dec_reg_write), .mem_to_reg(dec_mem_to_reg),
        .rd(dec_rd)
    );

    rv_execute ex0 (
        .clk(clk), .rst(rst), .alu_ctrl(alu_ctrl), .op_a_sel(op_a_sel), .op_b_sel(op_b_sel),
        .jump_kind(jump_kind), .funct3(funct3), .imm(imm), .mem_read_in(dec_mem_read),
        .mem_write_in(dec_mem_write), .reg_write_in(dec_reg_write),
        .mem_to_reg_in(dec_mem_to_reg), .rd_in(dec_rd), .rs1_value(rs1_value),
        .rs2_value(rs2_value), .pc(pc), .alu_result(alu_result), .alu_ctrl_q(alu_ctrl_q),
        .alu_a(alu_a), .alu_b(alu_b), .result(result), .target(target),
        .take_jump(take_jump), .mem_read(mem_read), .mem_write(mem_write),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .rd(rd), .store_data(store_data)
    );

    rv_alu alu0 (.alu_ctrl(alu_ctrl_q), .a(alu_a), .b(alu_b), .result(alu_result));

endmodule

//--- tb/rv_exec_assert.sv
`timescale 1ns/1ps

module rv_exec_assert (
    input logic                                clk,
    input logic                                rst,
    input logic                                mem_read,
    input logic                                mem_write,
    input logic                                reg_write,
    input logic                                mem_to_reg,
    input logic                                take_jump,
    input logic [4:0]                          rd,
    input logic [rv_ctrl_pkg::jump_kind_w-1:0] jump_kind,
    input logic [31:0]                         target
);
    import rv_ctrl_pkg::*;

    // A stage held in reset must look like a bubble
    a_reset_idle: assert property (@(posedge clk) rst |-> !reg_write && !mem_read &&
                                   !mem_write && !mem_to_reg && !take_jump && rd == 5'd0)
        else $error("Stage controls active while in reset");

    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("Load and store flagged together"); // One memory access per instruction

    // A JALR accepted at one edge jumps to an even target on the next
    a_jalr_align: assert property (@(posedge clk) disable iff (rst)
                                   (jump_kind == jmp_jalr) |=> take_jump && !target[0])
        else $error("JALR did not jump to an even target");

endmodule

bind rv_execute rv_exec_assert asrt0 (
    .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
    .reg_write(reg_write), .mem_to_reg(mem_to_reg), .take_jump(take_jump), .rd(rd),
    .jump_kind(jump_kind), .target(target)
);

//--- tb/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int reset_cycles = 16;
    localparam int table_rows   = 47; // Directed rows over all phases together
    localparam int random_rows  = 32;
    localparam int cycle_limit  = reset_cycles + table_rows + random_rows + 20;

    localparam logic [31:0] va = 32'h8000_0f30; // Negative when read as signed
    localparam logic [31:0] vb = 32'h0000_0023; // Low five bits give a shift of 3

    // Expected flag bits per row {take_jump, reg_write, mem_read, mem_write}
    localparam logic [3:0] fl_jump = 4'b1000;
    localparam logic [3:0] fl_wr   = 4'b0100;
    localparam logic [3:0] fl_ld   = 4'b0010;
    localparam logic [3:0] fl_st   = 4'b0001;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr, rs1_value, rs2_value, pc;
    logic [31:0] result, target, store_data;
    logic        take_jump, mem_read, mem_write, reg_write, mem_to_reg;
    logic [4:0]  rd;

    // Stimulus and expected values with one entry per row
    logic [31:0] t_instr [0:63];
    logic [31:0] t_a [0:63];
    logic [31:0] t_b [0:63];
    logic [31:0] t_pc [0:63];
    logic [31:0] t_res [0:63];
    logic [31:0] t_tgt [0:63];
    logic        t_chk [0:63]; // Result is only meaningful for some rows
    logic [3:0]  t_fl [0:63];
    logic [4:0]  t_rd [0:63];

    int          n_rows = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h84e3;

    rv_exec_top dut0 (
        .clk(clk), .rst(rst), .instr(instr), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .pc(pc), .result(result), .target(target), .take_jump(take_jump),
        .mem_read(mem_read), .mem_write(mem_write), .store_data(store_data),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .rd(rd)
    );

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // One instruction encoder per format
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rdi,
                                          input logic [6:0] opc);
        enc_r = {f7, rs2, rs1, f3, rdi, opc};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rdi,
                                          input logic [6:0] opc);
        enc_i = {imm[11:0], rs1, f3, rdi, opc};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rdi,
                                          input logic [6:0] opc);
        enc_u = {imm, rdi, opc};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input logic [4:0] rdi);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rdi, opc_jal};
    endfunction

    // Taps 32, 22, 2 and 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] w);
        w = '0;
        repeat (n)
        begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]}; // One step per bit
        end
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_fail++;
        end
        else
            n_pass++;
    endtask

    task automatic add_row(input logic [31:0] ins, a, b, p, input logic chk,
                           input logic [31:0] res, tgt, input logic [3:0] fl,
                           input logic [4:0] r);
        t_instr[n_rows] = ins;
        t_a[n_rows]     = a;
        t_b[n_rows]     = b;
        t_pc[n_rows]    = p;
        t_chk[n_rows]   = chk;
        t_res[n_rows]   = res;
        t_tgt[n_rows]   = tgt;
        t_fl[n_rows]    = fl;
        t_rd[n_rows]    = r;
        n_rows++;
    endtask

    task automatic check_row(input int r);
        check_val(take_jump, t_fl[r][3], $sformatf("row %0d take_jump", r));
        check_val(reg_write, t_fl[r][2], $sformatf("row %0d reg_write", r));
        check_val(mem_read, t_fl[r][1], $sformatf("row %0d mem_read", r));
        check_val(mem_to_reg, t_fl[r][1], $sformatf("row %0d mem_to_reg", r)); // Loads only
        check_val(mem_write, t_fl[r][0], $sformatf("row %0d mem_write", r));
        check_val(rd, t_rd[r], $sformatf("row %0d rd", r));
        check_val(store_data, t_b[r], $sformatf("row %0d store_data", r));
        if (t_chk[r])
            check_val(result, t_res[r], $sformatf("row %0d result", r));
        if (t_fl[r][3])
            check_val(target, t_tgt[r], $sformatf("row %0d target", r)); // Only taken rows
    endtask

    task automatic check_idle(input string when);
        check_val(reg_write, 1'b0, {when, " reg_write"});
        check_val(mem_read, 1'b0, {when, " mem_read"});
        check_val(mem_write, 1'b0, {when, " mem_write"});
        check_val(mem_to_reg, 1'b0, {when, " mem_to_reg"});
        check_val(take_jump, 1'b0, {when, " take_jump"});
        check_val(rd, 5'd0, {when, " rd"});
        check_val(result, 32'd0, {when, " result"});
        check_val(target, 32'd0, {when, " target"});
    endtask

    task automatic report_test(input string name, input int c0, input int f0);
        $display("test %s: %0d checks, %0d failed", name, n_pass + n_fail - c0, n_fail - f0);
    endtask

    // Each row is checked one falling edge after it was driven, so rows overlap back to back
    task automatic run_table(input string name);
        int c0;
        int f0;
        c0 = n_pass + n_fail;
        f0 = n_fail;
        for (int k = 0; k <= n_rows; k++)
        begin
            @(negedge clk);
            if (k > 0)
                check_row(k - 1);
            if (k < n_rows)
            begin
                instr     = t_instr[k];
                rs1_value = t_a[k];
                rs2_value = t_b[k];
                pc        = t_pc[k];
            end
            else
                instr = '0; // Trailing bubble
        end
        report_test(name, c0, f0);
        n_rows = 0;
    endtask

    initial
    begin
        logic [31:0] ra, rb, sel;
        logic [4:0]  rdr;
        rst       = 1'b1;
        instr     = '0;
        rs1_value = '0;
        rs2_value = '0;
        pc        = '0;

        repeat (reset_cycles) @(negedge clk);
        check_idle("in reset");
        rst = 1'b0;
        @(negedge clk);
        check_idle("after reset"); // Zero word was sampled as a bubble
        report_test("reset", 0, 0);

        // Every OP and OP-IMM function, then LUI
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_add_sub, 5'd5, opc_op), va, vb, 0, 1, va + vb, 0,
                fl_wr, 5'd5);
        add_row(enc_r(f7_alt, 5'd2, 5'd1, f3_add_sub, 5'd5, opc_op), va, vb, 0, 1, va - vb, 0,
                fl_wr, 5'd5);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_sll, 5'd6, opc_op), va, vb, 0, 1, va << 3, 0,
                fl_wr, 5'd6);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_slt, 5'd7, opc_op), va, vb, 0, 1, 32'd1, 0,
                fl_wr, 5'd7);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_sltu, 5'd8, opc_op), va, vb, 0, 1, 32'd0, 0,
                fl_wr, 5'd8);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_xor, 5'd9, opc_op), va, vb, 0, 1, va ^ vb, 0,
                fl_wr, 5'd9);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_srl_sra, 5'd10, opc_op), va, vb, 0, 1, va >> 3, 0,
                fl_wr, 5'd10);
        add_row(enc_r(f7_alt, 5'd2, 5'd1, f3_srl_sra, 5'd11, opc_op), va, vb, 0, 1,
                $signed(va) >>> 3, 0, fl_wr, 5'd11);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_or, 5'd12, opc_op), va, vb, 0, 1, va | vb, 0,
                fl_wr, 5'd12);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_and, 5'd13, opc_op), va, vb, 0, 1, va & vb, 0,
                fl_wr, 5'd13);
        add_row(enc_i(-16, 5'd1, f3_add_sub, 5'd14, opc_op_imm), va, vb, 0, 1,
                va + 32'hffff_fff0, 0, fl_wr, 5'd14);
        add_row(enc_i(5, 5'd1, f3_slt, 5'd15, opc_op_imm), va, vb, 0, 1, 32'd1, 0,
                fl_wr, 5'd15);
        add_row(enc_i(5, 5'd1, f3_sltu, 5'd16, opc_op_imm), va, vb, 0, 1, 32'd0, 0,
                fl_wr, 5'd16);
        add_row(enc_i(12'h7ff, 5'd1, f3_xor, 5'd17, opc_op_imm), va, vb, 0, 1, va ^ 32'h7ff, 0,
                fl_wr, 5'd17);
        add_row(enc_i(-256, 5'd1, f3_or, 5'd18, opc_op_imm), va, vb, 0, 1,
                va | 32'hffff_ff00, 0, fl_wr, 5'd18);
        add_row(enc_i(12'h0ff, 5'd1, f3_and, 5'd19, opc_op_imm), va, vb, 0, 1, va & 32'hff, 0,
                fl_wr, 5'd19);
        add_row(enc_i(4, 5'd1, f3_sll, 5'd20, opc_op_imm), va, vb, 0, 1, va << 4, 0,
                fl_wr, 5'd20);
        add_row(enc_i(7, 5'd1, f3_srl_sra, 5'd21, opc_op_imm), va, vb, 0, 1, va >> 7, 0,
                fl_wr, 5'd21);
        add_row(enc_i(12'h407, 5'd1, f3_srl_sra, 5'd22, opc_op_imm), va, vb, 0, 1,
                $signed(va) >>> 7, 0, fl_wr, 5'd22); // SRAI carries f7_alt in the immediate
        add_row(enc_u(20'habcde, 5'd9, opc_lui), va, vb, 0, 1, 32'habcd_e000, 0, fl_wr, 5'd9);
        run_table("alu");

        // Address arithmetic for memory access and AUIPC
        add_row(enc_i(-4, 5'd1, 3'b010, 5'd6, opc_load), 32'h1000, 32'h55, 0, 1,
                32'h1000 - 4, 0, fl_ld | fl_wr, 5'd6);
        add_row(enc_s(20, 5'd2, 5'd1, 3'b010), 32'h2000, 32'hdead_beef, 0, 1, 32'h2014, 0,
                fl_st, 5'd0);
        add_row(enc_s(-33, 5'd2, 5'd1, 3'b010), 32'h2000, 32'h1234_5678, 0, 1,
                32'h2000 - 33, 0, fl_st, 5'd0);
        add_row(enc_u(20'h00012, 5'd7, opc_auipc), 32'h9, 32'h3, 32'h400, 1,
                32'h400 + 32'h12000, 0, fl_wr, 5'd7);
        run_table("memory");

        // Each condition once taken and once not taken
        add_row(enc_b(16, 5'd2, 5'd1, f3_beq), 5, 5, 32'h100, 0, 0, 32'h100 + 16, fl_jump, 0);
        add_row(enc_b(16, 5'd2, 5'd1, f3_beq), 5, 6, 32'h100, 0, 0, 0, 4'b0, 0);
        add_row(enc_b(-32, 5'd2, 5'd1, f3_bne), 5, 6, 32'h100, 0, 0, 32'h100 - 32, fl_jump, 0);
        add_row(enc_b(-32, 5'd2, 5'd1, f3_bne), 5, 5, 32'h100, 0, 0, 0, 4'b0, 0);
        add_row(enc_b(2046, 5'd2, 5'd1, f3_blt), 32'hffff_ffff, 1, 32'h200, 0, 0,
                32'h200 + 2046, fl_jump, 0);
        add_row(enc_b(2046, 5'd2, 5'd1, f3_blt), 1, 32'hffff_ffff, 32'h200, 0, 0, 0, 4'b0, 0);
        add_row(enc_b(-4096, 5'd2, 5'd1, f3_bge), 1, 32'hffff_ffff, 32'h2000, 0, 0,
                32'h2000 - 4096, fl_jump, 0);
        add_row(enc_b(-4096, 5'd2, 5'd1, f3_bge), 32'hffff_ffff, 1, 32'h2000, 0, 0, 0, 4'b0, 0);
        add_row(enc_b(8, 5'd2, 5'd1, f3_bltu), 1, 32'hffff_ffff, 32'h300, 0, 0, 32'h308,
                fl_jump, 0);
        add_row(enc_b(8, 5'd2, 5'd1, f3_bltu), 32'hffff_ffff, 1, 32'h300, 0, 0, 0, 4'b0, 0);
        add_row(enc_b(-8, 5'd2, 5'd1, f3_bgeu), 32'hffff_ffff, 1, 32'h300, 0, 0, 32'h2f8,
                fl_jump, 0);
        add_row(enc_b(-8, 5'd2, 5'd1, f3_bgeu), 1, 32'hffff_ffff, 32'h300, 0, 0, 0, 4'b0, 0);
        run_table("branch");

        // Link value is pc + 4 for both jumps
        add_row(enc_j(2048, 5'd1), 0, 0, 32'h200, 1, 32'h204, 32'h200 + 2048,
                fl_jump | fl_wr, 5'd1);
        add_row(enc_j(-4, 5'd1), 0, 0, 32'h1000, 1, 32'h1004, 32'h1000 - 4,
                fl_jump | fl_wr, 5'd1);
        add_row(enc_i(4, 5'd1, 3'b000, 5'd1, opc_jalr), 32'h3001, 0, 32'h500, 1, 32'h504,
                (32'h3001 + 4) & ~32'h1, fl_jump | fl_wr, 5'd1); // Odd sum loses bit 0
        add_row(enc_i(-7, 5'd1, 3'b000, 5'd5, opc_jalr), 32'h4000, 0, 32'h600, 1, 32'h604,
                (32'h4000 - 7) & ~32'h1, fl_jump | fl_wr, 5'd5);
        run_table("jump");

        // Bubbles, writes to x0, then plain rows back to back
        add_row(32'hffff_ffff, 32'h11, 32'h22, 32'h40, 0, 0, 0, 4'b0, 0);
        add_row(32'h0000_0000, 32'h33, 32'h44, 32'h44, 0, 0, 0, 4'b0, 0);
        add_row(32'h0000_000f, 32'h55, 32'h66, 32'h48, 0, 0, 0, 4'b0, 0);
        add_row(32'h0000_0073, 32'h77, 32'h88, 32'h4c, 0, 0, 0, 4'b0, 0);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_add_sub, 5'd0, opc_op), 5, 7, 0, 1, 12, 0, 4'b0, 0);
        add_row(enc_r(7'd0, 5'd2, 5'd1, f3_add_sub, 5'd3, opc_op), 32'h100, 32'h11, 0, 1,
                32'h111, 0, fl_wr, 5'd3);
        add_row(enc_r(f7_alt, 5'd2, 5'd1, f3_add_sub, 5'd4, opc_op), 32'h100, 32'h11, 0, 1,
                32'h100 - 32'h11, 0, fl_wr, 5'd4);
        run_table("bubble");

        // Random operands for ADD, XOR and SLTU
        for (int k = 0; k < random_rows; k++)
        begin
            take_bits(32, ra);
            take_bits(32, rb);
            take_bits(2, sel);
            rdr = 5'(k % 31 + 1);
            if (sel[1:0] == 2'd1)
                add_row(enc_r(7'd0, 5'd2, 5'd1, f3_xor, rdr, opc_op), ra, rb, 0, 1, ra ^ rb, 0,
                        fl_wr, rdr);
            else if (sel[1:0] == 2'd2)
                add_row(enc_r(7'd0, 5'd2, 5'd1, f3_sltu, rdr, opc_op), ra, rb, 0, 1,
                        {31'd0, ra < rb}, 0, fl_wr, rdr);
            else
                add_row(enc_r(7'd0, 5'd2, 5'd1, f3_add_sub, rdr, opc_op), ra, rb, 0, 1,
                        ra + rb, 0, fl_wr, rdr);
        end
        run_table("random");

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- vlog.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_decoder.sv
src/rv_alu.sv
src/rv_execute.sv
src/rv_exec_top.sv
tb/rv_exec_assert.sv
tb/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - src/rv_isa_pkg.sv
  - src/rv_ctrl_pkg.sv
  - src/rv_decoder.sv
  - src/rv_alu.sv
  - src/rv_execute.sv
  - src/rv_exec_top.sv
  - target: test
    files:
      - tb/rv_exec_assert.sv
      - tb/rv_exec_tb.sv
